//--- source/xc_config_pkg.sv
// correlator arithmetic types
package xc_config_pkg;

	// one count must hold a full window of coincidences.
	localparam int COUNT_BITS = 16;

	// samples accepted so far in the window.
	localparam int WINDOW_BITS = 16;

	typedef logic [COUNT_BITS-1:0] count_t;
	typedef logic [WINDOW_BITS-1:0] window_count_t;

	// distinct input pairs.
	function automatic int num_baselines(
		input int num_inputs
	);
		return num_inputs * (num_inputs - 1) / 2;
	endfunction

	// pulses, then autocorrelation, then cross-correlation lags.
	function automatic int payload_words(
		input int num_inputs,
		input int lag_auto,
		input int lag_cross
	);
		int auto_words;
		int cross_words;
		auto_words = num_inputs * lag_auto;
		cross_words = num_baselines(num_inputs) * (2 * lag_cross - 1);
		return num_inputs + auto_words + cross_words;
	endfunction

	// lag slots per baseline, negative through positive.
	function automatic int cross_lags(
		input int lag_cross
	);
		return 2 * lag_cross - 1;
	endfunction

endpackage

//--- source/xc_packet_pkg.sv
// output stream word types
package xc_packet_pkg;

	localparam int WORD_BITS = 16;

	// geometry word and sequence word.
	localparam int HEADER_WORDS = 2;

	typedef logic [WORD_BITS-1:0] word_t;

	// one nibble of header word 0.
	typedef logic [3:0] hdr_field_t;

	// feature flags, bit 0 is cross-correlation.
	localparam hdr_field_t FLAG_CROSS = 4'd1;

	typedef struct packed {
		word_t data;
		logic  first; // header word 0.
		logic  last;  // final payload word.
	} pkt_word_t;

endpackage

//--- source/sample_delay_line.sv
// sample history shift register
module sample_delay_line #(
	parameter int DEPTH = 1
) (
	input  logic           intclk,
	input  logic           rst,
	input  logic           shift_en,
	input  logic           din,
	output logic [DEPTH:0] taps
);

	logic [DEPTH:1] hist; // hist[k] is k accepted samples back.

	always_ff @(posedge intclk) begin
		if (rst) begin
			hist <= '0;
		end else if (shift_en) begin
			hist[1] <= din;
			for (int k = 2; k <= DEPTH; k++) begin
				hist[k] <= hist[k-1];
			end
		end
	end

	// tap 0 is the sample being accepted right now.
	assign taps = {hist, din};

	a_hold_history: assert property (
		@(posedge intclk) disable iff (rst)
		!shift_en |=> $stable(taps[DEPTH:1])
	) else $error("delay line history moved without shift_en");

endmodule

//--- source/coincidence_counter.sv
// windowed coincidence counter
module coincidence_counter (
	input  logic                  intclk,
	input  logic                  rst,
	input  logic                  hit,
	input  logic                  shift_en,
	input  logic                  window_end,
	output xc_config_pkg::count_t snapshot
);

	import xc_config_pkg::*;

	count_t count;      // running total of this window.
	count_t next_count;

	assign next_count = count + count_t'(hit);

	always_ff @(posedge intclk) begin
		if (rst) begin
			count <= '0;
		end else if (shift_en) begin
			if (window_end) begin
				count <= '0; // fresh window.
			end else begin
				count <= next_count;
			end
		end
	end

	// last sample of the window is included in the snapshot.
	always_ff @(posedge intclk) begin
		if (shift_en && window_end) begin
			snapshot <= next_count;
		end
	end

	a_end_with_shift: assert property (
		@(posedge intclk) disable iff (rst)
		window_end |-> shift_en
	) else $error("window_end without an accepted sample");

endmodule

//--- source/correlator_array.sv
// delay lines and counter array
module correlator_array #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_AUTO   = 2,
	parameter int LAG_CROSS  = 2
) (
	input  logic                  intclk,
	input  logic                  rst,
	input  logic [NUM_INPUTS-1:0] sample,
	input  logic                  shift_en,
	input  logic                  window_end,
	output xc_config_pkg::count_t
		[xc_config_pkg::payload_words(NUM_INPUTS, LAG_AUTO, LAG_CROSS)-1:0] frame,
	output logic                  frame_pending,
	input  logic                  frame_taken
);

	import xc_config_pkg::*;

	localparam int PAYLOAD_WORDS = payload_words(NUM_INPUTS, LAG_AUTO, LAG_CROSS);
	localparam int XC_LAGS       = cross_lags(LAG_CROSS);
	localparam int AUTO_BASE     = NUM_INPUTS;
	localparam int XC_BASE       = NUM_INPUTS + NUM_INPUTS * LAG_AUTO;
	localparam int MAX_LAG       = (LAG_AUTO > LAG_CROSS) ? LAG_AUTO : LAG_CROSS;
	localparam int DEPTH         = (MAX_LAG > 1) ? MAX_LAG - 1 : 1;

	logic [DEPTH:0]         taps [NUM_INPUTS];
	logic [PAYLOAD_WORDS-1:0] hits; // one coincidence per payload word.

	for (genvar a = 0; a < NUM_INPUTS; a++) begin : g_input
		sample_delay_line #(
			.DEPTH(DEPTH)
		) delay_i (
			.intclk  (intclk),
			.rst     (rst),
			.shift_en(shift_en),
			.din     (sample[a]),
			.taps    (taps[a])
		);

		assign hits[a] = taps[a][0]; // pulse count.

		for (genvar l = 0; l < LAG_AUTO; l++) begin : g_auto
			assign hits[AUTO_BASE + a * LAG_AUTO + l] = taps[a][0] & taps[a][l];
		end

		// pairs (a,b) with b above a, numbered row by row.
		for (genvar b = a + 1; b < NUM_INPUTS; b++) begin : g_pair
			localparam int PAIR = a * (2 * NUM_INPUTS - a - 1) / 2 + (b - a - 1);
			for (genvar j = 0; j < XC_LAGS; j++) begin : g_lag
				localparam int D = j - (LAG_CROSS - 1);
				if (D >= 0) begin : g_pos
					assign hits[XC_BASE + PAIR * XC_LAGS + j] = taps[a][0] & taps[b][D];
				end else begin : g_neg
					assign hits[XC_BASE + PAIR * XC_LAGS + j] = taps[a][-D] & taps[b][0];
				end
			end
		end
	end

	for (genvar w = 0; w < PAYLOAD_WORDS; w++) begin : g_count
		coincidence_counter count_i (
			.intclk    (intclk),
			.rst       (rst),
			.hit       (hits[w]),
			.shift_en  (shift_en),
			.window_end(window_end),
			.snapshot  (frame[w])
		);
	end

	// a new window end re-arms even if the old frame leaves now.
	always_ff @(posedge intclk) begin
		if (rst) begin
			frame_pending <= 1'b0;
		end else if (window_end) begin
			frame_pending <= 1'b1;
		end else if (frame_taken) begin
			frame_pending <= 1'b0;
		end
	end

	a_no_overrun: assert property (
		@(posedge intclk) disable iff (rst)
		window_end |-> (!frame_pending || frame_taken)
	) else $error("window ended over a frame still pending");

endmodule

//--- source/integration_control.sv
// input handshake and window count
module integration_control #(
	parameter int WINDOW_SAMPLES = 16
) (
	input  logic intclk,
	input  logic rst,
	input  logic sample_valid,
	output logic sample_ready,
	input  logic frame_pending,
	input  logic frame_taken,
	output logic shift_en,
	output logic window_end
);

	import xc_config_pkg::*;

	window_count_t win_cnt; // samples accepted this window.
	logic          last_sample;

	// snapshots are busy until the serializer takes them.
	assign sample_ready = !frame_pending || frame_taken;
	assign shift_en     = sample_valid && sample_ready;

	assign last_sample = (win_cnt == window_count_t'(WINDOW_SAMPLES - 1));
	assign window_end  = shift_en && last_sample;

	always_ff @(posedge intclk) begin
		if (rst) begin
			win_cnt <= '0;
		end else if (window_end) begin
			win_cnt <= '0;
		end else if (shift_en) begin
			win_cnt <= win_cnt + 1'b1;
		end
	end

	// upstream must hold valid until the sample is taken.
	a_valid_held: assert property (
		@(posedge intclk) disable iff (rst)
		sample_valid && !sample_ready |=> sample_valid
	) else $error("sample_valid dropped before transfer");

endmodule

//--- source/packet_serializer.sv
// frame to word stream serializer
module packet_serializer #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_AUTO   = 2,
	parameter int LAG_CROSS  = 2
) (
	input  logic                     intclk,
	input  logic                     rst,
	input  xc_config_pkg::count_t
		[xc_config_pkg::payload_words(NUM_INPUTS, LAG_AUTO, LAG_CROSS)-1:0] frame,
	input  logic                     frame_valid,
	output logic                     frame_ready,
	output xc_packet_pkg::pkt_word_t out_word,
	output logic                     out_valid,
	input  logic                     out_ready
);

	import xc_config_pkg::*;
	import xc_packet_pkg::*;

	localparam int PAYLOAD_WORDS = payload_words(NUM_INPUTS, LAG_AUTO, LAG_CROSS);
	localparam int MAX_WORDS     = (PAYLOAD_WORDS > HEADER_WORDS) ? PAYLOAD_WORDS : HEADER_WORDS;
	localparam int IDX_BITS      = $clog2(MAX_WORDS);

	localparam logic [IDX_BITS-1:0] LAST_HDR = IDX_BITS'(HEADER_WORDS - 1);
	localparam logic [IDX_BITS-1:0] LAST_PAY = IDX_BITS'(PAYLOAD_WORDS - 1);

	// geometry and feature word.
	localparam word_t HDR0 = {hdr_field_t'(NUM_INPUTS - 1), hdr_field_t'(LAG_AUTO - 1),
		hdr_field_t'(LAG_CROSS - 1), FLAG_CROSS};

	typedef enum logic [1:0] {
		S_IDLE,
		S_HEADER,
		S_PAYLOAD
	} ser_state_t;

	ser_state_t                  state;
	logic [IDX_BITS-1:0]         idx;     // word within header or payload.
	word_t                       seq;     // frame sequence number.
	count_t [PAYLOAD_WORDS-1:0]  frame_q;

	if (NUM_INPUTS > 16 || LAG_AUTO > 16 || LAG_CROSS > 16) begin : g_field_check
		$error("geometry does not fit the 4-bit header fields");
	end

	assign frame_ready = (state == S_IDLE);
	assign out_valid   = (state != S_IDLE);

	always_ff @(posedge intclk) begin
		if (rst) begin
			state <= S_IDLE;
			idx   <= '0;
			seq   <= '0;
		end else begin
			case (state)
				S_IDLE: if (frame_valid) begin
					state <= S_HEADER;
					idx   <= '0;
				end
				S_HEADER: if (out_ready) begin
					if (idx == LAST_HDR) begin
						state <= S_PAYLOAD;
						idx   <= '0;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				S_PAYLOAD: if (out_ready) begin
					if (idx == LAST_PAY) begin
						state <= S_IDLE;
						idx   <= '0;
						seq   <= seq + 1'b1; // wraps.
					end else begin
						idx <= idx + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge intclk) begin
		if (state == S_IDLE && frame_valid) begin
			frame_q <= frame;
		end
	end

	// only moves on a transfer, so stalls hold it.
	always_comb begin
		out_word = '0;
		case (state)
			S_HEADER: begin
				out_word.first = (idx == '0);
				out_word.data  = (idx == '0) ? HDR0 : seq;
			end
			S_PAYLOAD: begin
				out_word.data = frame_q[idx];
				out_word.last = (idx == LAST_PAY);
			end
			default: out_word = '0;
		endcase
	end

	a_stall_stable: assert property (
		@(posedge intclk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_word)
	) else $error("out_word changed while stalled");

endmodule

//--- source/correlator_top.sv
// lag correlator top level
module correlator_top #(
	parameter int NUM_INPUTS     = 4,
	parameter int LAG_AUTO       = 2,
	parameter int LAG_CROSS      = 2,
	parameter int WINDOW_SAMPLES = 16
) (
	input  logic                     intclk,
	input  logic                     rst,
	input  logic [NUM_INPUTS-1:0]    sample,
	input  logic                     sample_valid,
	output logic                     sample_ready,
	output xc_packet_pkg::pkt_word_t out_word,
	output logic                     out_valid,
	input  logic                     out_ready
);

	import xc_config_pkg::*;

	localparam int PAYLOAD_WORDS = payload_words(NUM_INPUTS, LAG_AUTO, LAG_CROSS);

	logic                       shift_en;
	logic                       window_end;
	logic                       frame_pending;
	logic                       frame_ready;
	logic                       frame_taken;
	count_t [PAYLOAD_WORDS-1:0] frame;

	// a count reaches at most WINDOW_SAMPLES.
	if (WINDOW_SAMPLES < 1 || WINDOW_SAMPLES > 2**COUNT_BITS - 1) begin : g_window_check
		$error("WINDOW_SAMPLES does not fit in a count");
	end

	assign frame_taken = frame_pending && frame_ready; // handoff to serializer.

	integration_control #(
		.WINDOW_SAMPLES(WINDOW_SAMPLES)
	) ctrl_i (
		.intclk       (intclk),
		.rst          (rst),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready),
		.frame_pending(frame_pending),
		.frame_taken  (frame_taken),
		.shift_en     (shift_en),
		.window_end   (window_end)
	);

	correlator_array #(
		.NUM_INPUTS(NUM_INPUTS),
		.LAG_AUTO  (LAG_AUTO),
		.LAG_CROSS (LAG_CROSS)
	) array_i (
		.intclk       (intclk),
		.rst          (rst),
		.sample       (sample),
		.shift_en     (shift_en),
		.window_end   (window_end),
		.frame        (frame),
		.frame_pending(frame_pending),
		.frame_taken  (frame_taken)
	);

	packet_serializer #(
		.NUM_INPUTS(NUM_INPUTS),
		.LAG_AUTO  (LAG_AUTO),
		.LAG_CROSS (LAG_CROSS)
	) ser_i (
		.intclk     (intclk),
		.rst        (rst),
		.frame      (frame),
		.frame_valid(frame_pending),
		.frame_ready(frame_ready),
		.out_word   (out_word),
		.out_valid  (out_valid),
		.out_ready  (out_ready)
	);

endmodule

//--- sim/correlator_clock_gen.sv
// testbench clock and reset
module correlator_clock_gen #(
	parameter int PERIOD       = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic intclk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		intclk = 1'b0;
		forever #(PERIOD / 2) intclk = ~intclk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge intclk);
		rst <= 1'b0; // released on a rising edge.
	end

endmodule

//--- sim/correlator_tb.sv
// lag correlator testbench
module correlator_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import xc_packet_pkg::*;

	localparam int N_IN        = 4;
	localparam int LAG_A       = 2;
	localparam int LAG_X       = 2;
	localparam int WIN         = 16;
	localparam int FRAMES      = 4;
	localparam int SEED        = 3640;
	localparam int PAYLOAD     = N_IN + N_IN * LAG_A + N_IN * (N_IN - 1) / 2 * (2 * LAG_X - 1);
	localparam int FRAME_WORDS = 2 + PAYLOAD;
	// samples plus words per frame, with room for random stalls.
	localparam int TIMEOUT_CYCLES = FRAMES * (WIN + FRAME_WORDS) * 5 + 40;
	localparam logic [15:0] HDR0 = {4'(N_IN - 1), 4'(LAG_A - 1), 4'(LAG_X - 1), 4'd1};

	logic            intclk;
	logic            rst;
	logic [N_IN-1:0] sample;
	logic            sample_valid;
	logic            sample_ready;
	pkt_word_t       out_word;
	logic            out_valid;
	logic            out_ready;

	logic [N_IN-1:0] accepted [$]; // every accepted sample, oldest first.
	pkt_word_t       exp_q [$];
	pkt_word_t       exp_head;
	logic            expect_valid = 1'b0;
	logic            sample_xfer = 1'b0; // transfer due on the next edge.
	int              n_accepted = 0;
	int              words_rx = 0;
	int              hdr_seen = 0;
	int              frames_closed = 0;
	int              input_stalls = 0;
	int              cycles = 0;

	correlator_clock_gen clk_gen_i (
		.intclk(intclk),
		.rst   (rst)
	);

	correlator_top #(
		.NUM_INPUTS    (N_IN),
		.LAG_AUTO      (LAG_A),
		.LAG_CROSS     (LAG_X),
		.WINDOW_SAMPLES(WIN)
	) dut_i (
		.intclk      (intclk),
		.rst         (rst),
		.sample      (sample),
		.sample_valid(sample_valid),
		.sample_ready(sample_ready),
		.out_word    (out_word),
		.out_valid   (out_valid),
		.out_ready   (out_ready)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		abort_run($sformatf("error at %0t ns: %s is %0h, expected %0h", $time, name, got, want));
	endtask

	// history before the first sample reads as zero.
	function automatic logic bit_at(input int n, input int a);
		if (n < 0) begin
			return 1'b0;
		end
		return accepted[n][a];
	endfunction

	// coincidences of x_a[n-da] and x_b[n-db] over window w.
	function automatic int count_window(input int w, input int a, input int da,
		input int b, input int db);
		int total;
		total = 0;
		for (int n = w * WIN; n < (w + 1) * WIN; n++) begin
			total += int'(bit_at(n - da, a) & bit_at(n - db, b));
		end
		return total;
	endfunction

	task automatic push_payload(input int value, inout int idx);
		pkt_word_t wd;
		wd      = '0;
		wd.data = 16'(value);
		wd.last = (idx == PAYLOAD - 1);
		exp_q.push_back(wd);
		idx++;
	endtask

	task automatic queue_frame(input int w);
		pkt_word_t wd;
		int        idx;
		wd       = '0;
		wd.first = 1'b1;
		wd.data  = HDR0;
		exp_q.push_back(wd);
		wd      = '0;
		wd.data = 16'(w); // sequence number.
		exp_q.push_back(wd);
		idx = 0;
		for (int a = 0; a < N_IN; a++) begin
			push_payload(count_window(w, a, 0, a, 0), idx);
		end
		for (int a = 0; a < N_IN; a++) begin
			for (int l = 0; l < LAG_A; l++) begin
				push_payload(count_window(w, a, 0, a, l), idx);
			end
		end
		for (int a = 0; a < N_IN; a++) begin
			for (int b = a + 1; b < N_IN; b++) begin
				for (int d = 1 - LAG_X; d < LAG_X; d++) begin
					if (d >= 0) begin
						push_payload(count_window(w, a, 0, b, d), idx);
					end else begin
						push_payload(count_window(w, a, -d, b, 0), idx); // x_a leads.
					end
				end
			end
		end
	endtask

	// random samples and back-pressure.
	always @(posedge intclk) begin
		if (!rst) begin
			out_ready <= ($urandom % 2) == 0;
			if (!sample_valid || sample_xfer) begin
				if (n_accepted < FRAMES * WIN && ($urandom % 4) != 0) begin
					sample       <= N_IN'($urandom);
					sample_valid <= 1'b1;
				end else begin
					sample_valid <= 1'b0;
				end
			end
		end
	end

	// model sees handshakes at the falling edge, ahead of the transfer.
	always @(negedge intclk) begin
		if (!rst) begin
			sample_xfer = sample_valid && sample_ready;
			if (sample_xfer) begin
				accepted.push_back(sample);
				n_accepted++;
				if (n_accepted % WIN == 0) begin
					queue_frame(frames_closed);
					frames_closed++;
				end
			end else if (sample_valid) begin
				input_stalls++;
			end
			if (out_valid && out_ready) begin
				expect_valid = exp_q.size() > 0;
				if (expect_valid) begin
					exp_head = exp_q.pop_front();
				end
				words_rx++;
				if (out_word.first) begin
					hdr_seen++;
				end
			end
		end
	end

	a_reset_idle: assert property (@(posedge intclk) disable iff (rst)
		n_accepted == 0 |-> !out_valid && sample_ready)
		else abort_run("out_valid or sample_ready wrong before the first sample");

	a_word_expected: assert property (@(posedge intclk) disable iff (rst)
		out_valid && out_ready |-> expect_valid)
		else abort_run("a word was sent while no frame was expected");

	a_word_data: assert property (@(posedge intclk) disable iff (rst)
		out_valid && out_ready |-> out_word.data == exp_head.data)
		else report_mismatch("out_word.data", $sampled(out_word.data), $sampled(exp_head.data));

	a_word_first: assert property (@(posedge intclk) disable iff (rst)
		out_valid && out_ready |-> out_word.first == exp_head.first)
		else report_mismatch("out_word.first", $sampled(out_word.first),
			$sampled(exp_head.first));

	a_word_last: assert property (@(posedge intclk) disable iff (rst)
		out_valid && out_ready |-> out_word.last == exp_head.last)
		else report_mismatch("out_word.last", $sampled(out_word.last), $sampled(exp_head.last));

	a_stall_hold: assert property (@(posedge intclk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_word))
		else abort_run("out_word changed while out_ready was low");

	// input stalls only behind a busy serializer and a finished frame.
	a_input_held_back: assert property (@(posedge intclk) disable iff (rst)
		!sample_ready |-> out_valid && frames_closed > hdr_seen)
		else abort_run("sample_ready dropped with no finished frame waiting");

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge intclk);
			cycles++;
		end
		abort_run($sformatf("timeout after %0d cycles with %0d words received", cycles, words_rx));
	end

	initial begin
		void'($urandom(SEED));
		sample       = '0;
		sample_valid = 1'b0;
		out_ready    = 1'b0;
		exp_head     = '0;
		while (words_rx < FRAMES * FRAME_WORDS) begin
			@(posedge intclk);
		end
		repeat (20) @(posedge intclk); // stray words would show here.
		if (n_accepted == FRAMES * WIN && words_rx == FRAMES * FRAME_WORDS &&
			exp_q.size() == 0 && input_stalls > 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			abort_run($sformatf("run ended with %0d samples, %0d words, %0d input stalls",
				n_accepted, words_rx, input_stalls));
		end
	end

endmodule

//--- correlator_top.f
source/xc_config_pkg.sv
source/xc_packet_pkg.sv
source/sample_delay_line.sv
source/coincidence_counter.sv
source/correlator_array.sv
source/integration_control.sv
source/packet_serializer.sv
source/correlator_top.sv
sim/correlator_clock_gen.sv
sim/correlator_tb.sv
